// ==== logic/uart_macros.svh ====
/* Width and reset-value macros shared by the UART register block, transmitter and receiver */

`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

// ------------------------------------------------------------------------
// Data path widths
// ------------------------------------------------------------------------

// One character and each 8-bit register
`define UART_DATA_W 8

// Baud divisor register, in clock cycles per bit
`define UART_BAUD_W 16

// Processor data bus
`define UART_BUS_W 16

// ------------------------------------------------------------------------
// Register values after reset
// ------------------------------------------------------------------------

`define UART_BAUD_RESET 16'd8
`define UART_TX_RESET   8'h4A

`endif

// ==== logic/uart_reg_pkg.sv ====
/* Register map of the UART: word addresses and bit positions in STATUS and CONTROL */

`default_nettype none

package uart_reg_pkg;

    // --------------------------------------------------------------------
    // Word addresses on the data bus
    // --------------------------------------------------------------------

    typedef enum logic [5:0] {
        RXDATA   = 6'd0,
        TXDATA   = 6'd1,
        BAUD     = 6'd2,
        CONTROL  = 6'd3,
        STATUS   = 6'd4,
        INT_MASK = 6'd5
    } uart_reg_e;

    // --------------------------------------------------------------------
    // STATUS bits
    // --------------------------------------------------------------------

    // Set by a received byte, cleared by software
    localparam int STAT_RX_FULL   = 0;
    // Transmitter can take a new byte
    localparam int STAT_TX_READY  = 1;
    // Stop bit sampled low
    localparam int STAT_FRAME_ERR = 4;

    // CONTROL bits
    localparam int CTRL_TWO_STOP  = 0;

endpackage

`default_nettype wire

// ==== logic/uart_frame_pkg.sv ====
/* State encodings of the transmit and receive frame machines */

`default_nettype none

package uart_frame_pkg;

    // Transmitter: line idle, start bit, 8 data bits, one or two stop bits
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_e;

    // --------------------------------------------------------------------
    // Receiver
    // --------------------------------------------------------------------

    // START waits half a bit to confirm the falling edge was a real start
    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

endpackage

`default_nettype wire

// ==== logic/uart_tx.sv ====
/* UART transmitter: start bit, 8 data bits LSB first, one or two stop bits */

`default_nettype none

`include "uart_macros.svh"

module uart_tx import uart_frame_pkg::*; (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic [`UART_DATA_W-1:0] tx_data_i,
    input  wire logic                    valid_i,
    input  wire logic                    two_stop_i,
    input  wire logic [`UART_BAUD_W-1:0] baud_div_i,
    output logic                         txd_o,
    output logic                         ready_o
);

    tx_state_e               state_q;
    logic [`UART_BAUD_W-1:0] baud_cnt_q;
    logic [2:0]              bit_cnt_q;
    logic [`UART_DATA_W-1:0] shift_q;
    logic                    extra_stop_q;
    logic                    bit_done;
    logic                    accept;

    assign bit_done = (baud_cnt_q == baud_div_i - 1'b1);
    assign ready_o  = (state_q == TX_IDLE);
    assign accept   = valid_i && ready_o;

    // ------------------------------------------------------------------------
    // Frame sequencing
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q      <= TX_IDLE;
            txd_o        <= 1'b1;
            baud_cnt_q   <= '0;
            bit_cnt_q    <= '0;
            extra_stop_q <= 1'b0;
        end else begin
            baud_cnt_q <= bit_done ? '0 : baud_cnt_q + 1'b1;
            case (state_q)
                TX_IDLE: begin
                    txd_o      <= 1'b1;
                    baud_cnt_q <= '0;
                    if (accept) begin
                        // Stop-bit mode is frozen for the whole frame
                        extra_stop_q <= two_stop_i;
                        txd_o        <= 1'b0;
                        state_q      <= TX_START;
                    end
                end
                TX_START: begin
                    if (bit_done) begin
                        txd_o     <= shift_q[0];
                        bit_cnt_q <= '0;
                        state_q   <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (bit_done) begin
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                        if (bit_cnt_q == 3'd7) begin
                            txd_o   <= 1'b1;
                            state_q <= TX_STOP;
                        end else begin
                            txd_o <= shift_q[0];
                        end
                    end
                end
                default: begin
                    if (bit_done) begin
                        // Second stop bit repeats this state once
                        if (extra_stop_q) begin
                            extra_stop_q <= 1'b0;
                        end else begin
                            state_q <= TX_IDLE;
                        end
                    end
                end
            endcase
        end
    end

    // Byte shifter, loaded on accept and advanced after each bit leaves
    always_ff @(posedge clk) begin
        if (accept) begin
            shift_q <= tx_data_i;
        end else if (bit_done && (state_q == TX_START || state_q == TX_DATA)) begin
            shift_q <= {1'b0, shift_q[`UART_DATA_W-1:1]};
        end
    end

endmodule

`default_nettype wire

// ==== logic/uart_rx.sv ====
/* UART receiver: input synchronizer, start-edge detection, mid-bit sampling and stop check */

`default_nettype none

`include "uart_macros.svh"

module uart_rx import uart_frame_pkg::*; (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic                    rxd_i,
    input  wire logic [`UART_BAUD_W-1:0] baud_div_i,
    output logic [`UART_DATA_W-1:0]      rx_data_o,
    output logic                         valid_o,
    output logic                         frame_err_o
);

    rx_state_e               state_q;
    logic                    rxd_meta_q;
    logic                    rxd_sync_q;
    logic                    rxd_prev_q;
    logic [`UART_BAUD_W-1:0] baud_cnt_q;
    logic [`UART_BAUD_W-1:0] half_div;
    logic [2:0]              bit_cnt_q;
    logic [`UART_DATA_W-1:0] shift_q;
    logic                    fall;
    logic                    mid_start;
    logic                    bit_done;
    logic                    sample_data;

    // ------------------------------------------------------------------------
    // Synchronizer and edge detect
    // ------------------------------------------------------------------------

    // Idle line level is high, so the flops reset to 1
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rxd_meta_q <= 1'b1;
            rxd_sync_q <= 1'b1;
            rxd_prev_q <= 1'b1;
        end else begin
            rxd_meta_q <= rxd_i;
            rxd_sync_q <= rxd_meta_q;
            rxd_prev_q <= rxd_sync_q;
        end
    end

    assign fall        = rxd_prev_q && !rxd_sync_q;
    assign half_div    = baud_div_i >> 1;
    assign mid_start   = (baud_cnt_q == half_div - 1'b1);
    assign bit_done    = (baud_cnt_q == baud_div_i - 1'b1);
    assign sample_data = (state_q == RX_DATA) && bit_done;

    // ------------------------------------------------------------------------
    // Frame FSM
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q     <= RX_IDLE;
            baud_cnt_q  <= '0;
            bit_cnt_q   <= '0;
            valid_o     <= 1'b0;
            frame_err_o <= 1'b0;
        end else begin
            valid_o     <= 1'b0;
            frame_err_o <= 1'b0;
            baud_cnt_q  <= baud_cnt_q + 1'b1;
            case (state_q)
                RX_IDLE: begin
                    baud_cnt_q <= '0;
                    if (fall) begin
                        state_q <= RX_START;
                    end
                end
                RX_START: begin
                    if (mid_start) begin
                        baud_cnt_q <= '0;
                        bit_cnt_q  <= '0;
                        // A high sample here was a glitch, not a start bit
                        state_q    <= rxd_sync_q ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (bit_done) begin
                        baud_cnt_q <= '0;
                        bit_cnt_q  <= bit_cnt_q + 1'b1;
                        if (bit_cnt_q == 3'd7) begin
                            state_q <= RX_STOP;
                        end
                    end
                end
                default: begin
                    if (bit_done) begin
                        valid_o     <= rxd_sync_q;
                        frame_err_o <= !rxd_sync_q;
                        state_q     <= RX_IDLE;
                    end
                end
            endcase
        end
    end

    // Data bits arrive LSB first
    always_ff @(posedge clk) begin
        if (sample_data) begin
            shift_q <= {rxd_sync_q, shift_q[`UART_DATA_W-1:1]};
        end
    end

    assign rx_data_o = shift_q;

endmodule

`default_nettype wire

// ==== logic/uart_regs.sv ====
/* UART register block: bus decode, six registers, read mux, status update and interrupt */

`default_nettype none

`include "uart_macros.svh"

module uart_regs import uart_reg_pkg::*; (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic                    sel_i,
    input  wire logic                    wr_en_i,
    input  wire logic [5:0]              addr_i,
    input  wire logic [`UART_BUS_W-1:0]  wdata_i,
    input  wire logic                    tx_ready_i,
    input  wire logic [`UART_DATA_W-1:0] rx_data_i,
    input  wire logic                    rx_valid_i,
    input  wire logic                    frame_err_i,
    output logic [`UART_BUS_W-1:0]       rdata_o,
    output logic                         ack_o,
    output logic                         irq_o,
    output logic [`UART_DATA_W-1:0]      tx_data_o,
    output logic                         tx_valid_o,
    output logic                         two_stop_o,
    output logic [`UART_BAUD_W-1:0]      baud_div_o
);

    logic                    rd_req;
    logic                    wr_req;
    logic                    txdata_wr;
    logic                    baud_wr;
    logic                    control_wr;
    logic                    status_wr;
    logic                    mask_wr;
    logic [`UART_BUS_W-1:0]  rmux;
    logic [`UART_DATA_W-1:0] status_next;

    logic [`UART_DATA_W-1:0] rxdata_q;
    logic [`UART_DATA_W-1:0] txdata_q;
    logic [`UART_BAUD_W-1:0] baud_q;
    logic [`UART_DATA_W-1:0] control_q;
    logic [`UART_DATA_W-1:0] status_q;
    logic [`UART_DATA_W-1:0] mask_q;

    // ------------------------------------------------------------------------
    // Bus decode
    // ------------------------------------------------------------------------

    // The cycle right after an ack is not served
    assign rd_req = sel_i && !wr_en_i && !ack_o;
    assign wr_req = sel_i && wr_en_i && !ack_o;

    always_comb begin
        txdata_wr  = 1'b0;
        baud_wr    = 1'b0;
        control_wr = 1'b0;
        status_wr  = 1'b0;
        mask_wr    = 1'b0;
        if (wr_req) begin
            case (addr_i)
                TXDATA:   txdata_wr  = 1'b1;
                BAUD:     baud_wr    = 1'b1;
                CONTROL:  control_wr = 1'b1;
                STATUS:   status_wr  = 1'b1;
                INT_MASK: mask_wr    = 1'b1;
                // RXDATA is read-only
                default: ;
            endcase
        end
    end

    always_comb begin
        case (addr_i)
            RXDATA:   rmux = {{(`UART_BUS_W-`UART_DATA_W){1'b0}}, rxdata_q};
            TXDATA:   rmux = {{(`UART_BUS_W-`UART_DATA_W){1'b0}}, txdata_q};
            BAUD:     rmux = baud_q;
            CONTROL:  rmux = {{(`UART_BUS_W-`UART_DATA_W){1'b0}}, control_q};
            STATUS:   rmux = {{(`UART_BUS_W-`UART_DATA_W){1'b0}}, status_q};
            INT_MASK: rmux = {{(`UART_BUS_W-`UART_DATA_W){1'b0}}, mask_q};
            default:  rmux = '0;
        endcase
    end

    // Status sources in priority order
    always_comb begin
        status_next = status_q;
        if (frame_err_i) begin
            status_next[STAT_FRAME_ERR] = 1'b1;
        end else if (rx_valid_i) begin
            status_next[STAT_RX_FULL] = 1'b1;
        end else if (status_wr) begin
            status_next = wdata_i[`UART_DATA_W-1:0];
        end else begin
            status_next[STAT_TX_READY] = tx_ready_i;
        end
    end

    // ------------------------------------------------------------------------
    // Registers and bus response
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rxdata_q   <= '0;
            txdata_q   <= `UART_TX_RESET;
            baud_q     <= `UART_BAUD_RESET;
            control_q  <= '0;
            status_q   <= '0;
            mask_q     <= '0;
            tx_valid_o <= 1'b0;
            ack_o      <= 1'b0;
            rdata_o    <= '0;
        end else begin
            if (rx_valid_i) rxdata_q <= rx_data_i;
            if (txdata_wr) txdata_q <= wdata_i[`UART_DATA_W-1:0];
            if (baud_wr) baud_q <= wdata_i[`UART_BAUD_W-1:0];
            if (control_wr) control_q <= wdata_i[`UART_DATA_W-1:0];
            if (mask_wr) mask_q <= wdata_i[`UART_DATA_W-1:0];
            status_q   <= status_next;
            // One-cycle start request for the transmitter
            tx_valid_o <= txdata_wr;
            ack_o      <= rd_req || wr_req;
            rdata_o    <= rd_req ? rmux : '0;
        end
    end

    assign tx_data_o  = txdata_q;
    assign two_stop_o = control_q[CTRL_TWO_STOP];
    assign baud_div_o = baud_q;
    assign irq_o      = |(status_q & mask_q);

endmodule

`default_nettype wire

// ==== logic/uart_top.sv ====
/* UART peripheral top: register block with transmitter and receiver */

`default_nettype none

`include "uart_macros.svh"

module uart_top (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   sel_i,
    input  wire logic                   wr_en_i,
    input  wire logic [5:0]             addr_i,
    input  wire logic [`UART_BUS_W-1:0] wdata_i,
    input  wire logic                   rxd_i,
    output logic [`UART_BUS_W-1:0]      rdata_o,
    output logic                        ack_o,
    output logic                        irq_o,
    output logic                        txd_o
);

    logic [`UART_DATA_W-1:0] tx_data;
    logic                    tx_valid;
    logic                    tx_ready;
    logic                    two_stop;
    logic [`UART_BAUD_W-1:0] baud_div;
    logic [`UART_DATA_W-1:0] rx_data;
    logic                    rx_valid;
    logic                    frame_err;

    uart_regs u_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .sel_i       (sel_i),
        .wr_en_i     (wr_en_i),
        .addr_i      (addr_i),
        .wdata_i     (wdata_i),
        .tx_ready_i  (tx_ready),
        .rx_data_i   (rx_data),
        .rx_valid_i  (rx_valid),
        .frame_err_i (frame_err),
        .rdata_o     (rdata_o),
        .ack_o       (ack_o),
        .irq_o       (irq_o),
        .tx_data_o   (tx_data),
        .tx_valid_o  (tx_valid),
        .two_stop_o  (two_stop),
        .baud_div_o  (baud_div)
    );

    uart_tx u_tx (
        .clk        (clk),
        .rst_n      (rst_n),
        .tx_data_i  (tx_data),
        .valid_i    (tx_valid),
        .two_stop_i (two_stop),
        .baud_div_i (baud_div),
        .txd_o      (txd_o),
        .ready_o    (tx_ready)
    );

    uart_rx u_rx (
        .clk         (clk),
        .rst_n       (rst_n),
        .rxd_i       (rxd_i),
        .baud_div_i  (baud_div),
        .rx_data_o   (rx_data),
        .valid_o     (rx_valid),
        .frame_err_o (frame_err)
    );

endmodule

`default_nettype wire

// ==== testbench/uart_tb.sv ====
/* UART testbench: clock, reset, bus tasks, transmit line monitor, loopback and
   framing-error stimulus, bus protocol assertions and watchdog */

`default_nettype none

`include "uart_macros.svh"

module uart_tb import uart_reg_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD = 4;
    localparam int MIN_DIV = 4;
    localparam int MAX_DIV = 19;
    localparam int FRAME_BUDGET = 20;
    localparam int WATCHDOG_NS = FRAME_BUDGET * 11 * MAX_DIV * CLK_PERIOD + 20000;
    localparam logic [31:0] SEED = 32'h86f609a3;

    logic                   clk;
    logic                   rst_n;
    logic                   sel;
    logic                   wr_en;
    logic [5:0]             addr;
    logic [`UART_BUS_W-1:0] wdata;
    logic [`UART_BUS_W-1:0] rdata;
    logic                   ack;
    logic                   irq;
    logic                   txd;
    logic                   loopback;
    logic                   rxd_drive;
    logic                   rxd_line;

    // Serial input comes either from our own transmitter or from the frame driver
    assign rxd_line = loopback ? txd : rxd_drive;

    uart_top uut (
        .clk     (clk),
        .rst_n   (rst_n),
        .sel_i   (sel),
        .wr_en_i (wr_en),
        .addr_i  (addr),
        .wdata_i (wdata),
        .rxd_i   (rxd_line),
        .rdata_o (rdata),
        .ack_o   (ack),
        .irq_o   (irq),
        .txd_o   (txd)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // Failure handling
    // ------------------------------------------------------------------------
    task automatic report_mismatch(input string msg);
        $display("ERROR @ %0d ns: %s", $time, msg);
        $display(">>> FAIL");
        $fatal(1, "stopping on first mismatch");
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic compare_word(input string what, input logic [15:0] got,
                                input logic [15:0] exp);
        assert (got == exp)
            else report_mismatch($sformatf("%s read 0x%04h, expected 0x%04h", what, got, exp));
    endtask

    // Bus protocol: single-cycle ack one cycle after each served request
    ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) ack |=> !ack)
        else report_mismatch("ack_o stayed high for two cycles");
    req_acked: assert property (@(posedge clk) disable iff (!rst_n) (sel && !ack) |=> ack)
        else report_mismatch("request not acknowledged one cycle later");
    no_stray_ack: assert property (@(posedge clk) disable iff (!rst_n) !(sel && !ack) |=> !ack)
        else report_mismatch("ack_o without a request");
    write_rdata_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (sel && wr_en && !ack) |=> (rdata == '0))
        else report_mismatch("write ack returned nonzero read data");

    // ------------------------------------------------------------------------
    // Bus tasks
    // ------------------------------------------------------------------------
    task automatic wait_ack();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (!ack && cycles >= 8) abort_run("Bus request was never acknowledged");
        end while (!ack);
        assert (cycles == 1)
            else report_mismatch($sformatf("ack_o came %0d cycles after the request", cycles));
    endtask

    task automatic bus_write(input logic [5:0] a, input logic [15:0] d);
        @(posedge clk);
        sel   <= 1'b1;
        wr_en <= 1'b1;
        addr  <= a;
        wdata <= d;
        @(posedge clk);
        sel   <= 1'b0;
        wr_en <= 1'b0;
        wait_ack();
    endtask

    task automatic bus_read(input logic [5:0] a, output logic [15:0] d);
        @(posedge clk);
        sel   <= 1'b1;
        wr_en <= 1'b0;
        addr  <= a;
        @(posedge clk);
        sel <= 1'b0;
        wait_ack();
        d = rdata;
    endtask

    task automatic wait_status_bit(input int bit_idx, input int max_polls);
        logic [15:0] st;
        int          polls;
        polls = 0;
        bus_read(STATUS, st);
        while (!st[bit_idx]) begin
            polls++;
            if (polls > max_polls) begin
                abort_run($sformatf("STATUS bit %0d never became set", bit_idx));
            end
            bus_read(STATUS, st);
        end
    endtask

    task automatic check_irq_matches();
        logic [15:0] st;
        logic [15:0] mask;
        bus_read(STATUS, st);
        bus_read(INT_MASK, mask);
        assert (irq == |(st[`UART_DATA_W-1:0] & mask[`UART_DATA_W-1:0]))
            else report_mismatch($sformatf("irq_o %b with STATUS 0x%02h and mask 0x%02h",
                                           irq, st[7:0], mask[7:0]));
    endtask

    // ------------------------------------------------------------------------
    // Serial line tasks
    // ------------------------------------------------------------------------

    // Expected line level in every cycle of the frame, starting at the start bit
    task automatic watch_tx_line(input logic [7:0] data, input int nbits, input int div);
        int   c;
        int   idx;
        logic exp_bit;
        for (c = 0; c < nbits * div; c++) begin
            @(negedge clk);
            idx = c / div;
            exp_bit = (idx == 0) ? 1'b0 : ((idx <= 8) ? data[idx-1] : 1'b1);
            assert (txd == exp_bit)
                else report_mismatch($sformatf("txd_o in bit %0d, cycle %0d: got %b, expected %b",
                                               idx, c, txd, exp_bit));
        end
    endtask

    task automatic check_tx_frame(input logic [7:0] data, input logic two_stop, input int div);
        logic [15:0] st;
        int          nbits;
        nbits = two_stop ? 11 : 10;
        bus_write(TXDATA, {8'h00, data});
        // Line still idle one cycle after the write is taken
        assert (txd == 1'b1) else report_mismatch("txd_o left idle too early");
        fork
            watch_tx_line(data, nbits, div);
            begin
                // Status read lands in the middle of the last stop bit
                repeat (nbits * div - div / 2) @(posedge clk);
                bus_read(STATUS, st);
                assert (st[STAT_TX_READY] == 1'b0)
                    else report_mismatch("STAT_TX_READY set during a frame");
            end
        join
        repeat (2) @(posedge clk);
        bus_read(STATUS, st);
        assert (st[STAT_TX_READY] == 1'b1) else report_mismatch("STAT_TX_READY clear after frame");
    endtask

    task automatic send_frame(input logic [7:0] data, input logic stop_level, input int div);
        int         i;
        logic [9:0] bits;
        bits = {stop_level, data, 1'b0};
        for (i = 0; i < 10; i++) begin
            @(posedge clk);
            rxd_drive <= bits[i];
            repeat (div - 1) @(posedge clk);
        end
        @(posedge clk);
        rxd_drive <= 1'b1;
        repeat (div) @(posedge clk);
    endtask

    task automatic loopback_frame(input logic [7:0] data, input int div, input logic two_stop);
        logic [15:0] got;
        bus_write(BAUD, 16'(div));
        bus_write(CONTROL, {15'h0000, two_stop});
        bus_write(STATUS, 16'h0000);
        bus_write(TXDATA, {8'h00, data});
        wait_status_bit(STAT_RX_FULL, 11 * div);
        bus_read(RXDATA, got);
        compare_word("RXDATA after loopback", got, {8'h00, data});
        bus_read(STATUS, got);
        assert (got[STAT_FRAME_ERR] == 1'b0) else report_mismatch("frame error on a good frame");
        wait_status_bit(STAT_TX_READY, 11 * div);
    endtask

    task automatic clear_rx_flag();
        logic [15:0] st;
        bus_write(STATUS, 16'h0000);
        bus_read(STATUS, st);
        assert (st[STAT_RX_FULL] == 1'b0) else report_mismatch("STAT_RX_FULL survived a clear");
    endtask

    // ------------------------------------------------------------------------
    // Test sequences
    // ------------------------------------------------------------------------
    task automatic check_reset_values();
        logic [15:0] got;
        bus_read(BAUD, got);
        compare_word("BAUD", got, 16'h0008);
        bus_read(TXDATA, got);
        compare_word("TXDATA", got, 16'h004A);
        bus_read(CONTROL, got);
        compare_word("CONTROL", got, 16'h0000);
        bus_read(INT_MASK, got);
        compare_word("INT_MASK", got, 16'h0000);
        bus_read(STATUS, got);
        compare_word("STATUS", got, 16'h0002);
        bus_read(6'd6, got);
        compare_word("unmapped 6", got, 16'h0000);
        bus_read(6'd63, got);
        compare_word("unmapped 63", got, 16'h0000);
        assert (txd == 1'b1) else report_mismatch("txd_o low after reset");
        assert (irq == 1'b0) else report_mismatch("irq_o high after reset");
    endtask

    task automatic check_register_access();
        logic [15:0] v;
        logic [15:0] got;
        int          i;
        for (i = 0; i < 4; i++) begin
            v = 16'($urandom);
            bus_write(BAUD, v);
            bus_read(BAUD, got);
            compare_word("BAUD", got, v);
            v = 16'($urandom);
            bus_write(CONTROL, v);
            bus_read(CONTROL, got);
            compare_word("CONTROL", got, {8'h00, v[7:0]});
            v = 16'($urandom);
            bus_write(INT_MASK, v);
            bus_read(INT_MASK, got);
            compare_word("INT_MASK", got, {8'h00, v[7:0]});
            bus_write(RXDATA, 16'($urandom));
            bus_read(RXDATA, got);
            compare_word("RXDATA after write", got, 16'h0000);
        end
        bus_write(BAUD, 16'h0008);
        bus_write(CONTROL, 16'h0000);
        bus_write(INT_MASK, 16'h0000);
    endtask

    // A held read is served every other cycle
    task automatic check_held_request();
        int k;
        @(posedge clk);
        sel   <= 1'b1;
        wr_en <= 1'b0;
        addr  <= BAUD;
        @(posedge clk);
        for (k = 0; k < 6; k++) begin
            @(negedge clk);
            assert (ack == ((k % 2) == 0))
                else report_mismatch($sformatf("held request, cycle %0d: ack_o %b", k, ack));
            if (ack) compare_word("BAUD held read", rdata, 16'h0008);
        end
        @(posedge clk);
        sel <= 1'b0;
        @(negedge clk);
    endtask

    task automatic check_framing_error();
        logic [15:0] st;
        int          div;
        div = MIN_DIV + int'($urandom % 16);
        bus_write(BAUD, 16'(div));
        bus_write(STATUS, 16'h0000);
        @(posedge clk);
        loopback <= 1'b0;
        send_frame(8'($urandom), 1'b0, div);
        wait_status_bit(STAT_FRAME_ERR, 8);
        bus_read(STATUS, st);
        assert (st[STAT_RX_FULL] == 1'b0) else report_mismatch("bad frame set STAT_RX_FULL");
        bus_write(STATUS, 16'h0000);
        @(posedge clk);
        loopback <= 1'b1;
    endtask

    task automatic check_interrupt();
        bus_write(INT_MASK, 16'h0001);
        loopback_frame(8'($urandom), MIN_DIV + int'($urandom % 16), 1'b0);
        assert (irq == 1'b1) else report_mismatch("irq_o low with RX_FULL set and unmasked");
        check_irq_matches();
        bus_write(STATUS, 16'h0000);
        assert (irq == 1'b0) else report_mismatch("irq_o still high after STATUS clear");
        check_irq_matches();
        bus_write(INT_MASK, 16'h0000);
        loopback_frame(8'($urandom), MIN_DIV + int'($urandom % 16), 1'b1);
        assert (irq == 1'b0) else report_mismatch("irq_o high with the mask clear");
        check_irq_matches();
    endtask

    // ------------------------------------------------------------------------
    // Main sequence and watchdog
    // ------------------------------------------------------------------------
    initial begin
        int   i;
        int   div;
        logic two_stop;
        void'($urandom(SEED));
        rst_n     = 1'b0;
        sel       = 1'b0;
        wr_en     = 1'b0;
        addr      = '0;
        wdata     = '0;
        loopback  = 1'b1;
        rxd_drive = 1'b1;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);

        check_reset_values();
        check_register_access();
        check_held_request();
        for (i = 0; i < 4; i++) begin
            div      = MIN_DIV + int'($urandom % 16);
            two_stop = i[0];
            bus_write(BAUD, 16'(div));
            bus_write(CONTROL, {15'h0000, two_stop});
            check_tx_frame(8'($urandom), two_stop, div);
        end
        for (i = 0; i < 6; i++) begin
            loopback_frame(8'($urandom), MIN_DIV + int'($urandom % 16), 1'($urandom));
            clear_rx_flag();
        end
        check_framing_error();
        check_interrupt();

        $display(">>> PASS");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        abort_run($sformatf("Watchdog expired after %0d ns with tests still running", WATCHDOG_NS));
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+logic
logic/uart_reg_pkg.sv
logic/uart_frame_pkg.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart_regs.sv
logic/uart_top.sv
testbench/uart_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the UART testbench with Verilator, run it and check the result line
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f flist.f --top-module uart_tb -o uart_sim

sim_out="$(./obj_dir/uart_sim 2>&1 || true)"
echo "$sim_out"

if grep -Fqx '>>> PASS' <<< "$sim_out"; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
